/* rtl/spim_pkg.sv */
`default_nettype none

package spim_pkg;

    ////////////////////////////////////////
    // data path widths
    ////////////////////////////////////////

    // one data word on the parallel ports
    localparam int WORD_W = 32;
    // quad bus, one nibble per beat
    localparam int NIB_W  = 4;
    localparam int NIBS   = WORD_W / NIB_W;

    // command fields
    localparam int SIZE_W = 16;
    localparam int BITS_W = 5;

    // beat index within a word, up to 32 beats in standard mode
    localparam int BEAT_W = 5;

    // a data word is either 32 single bits or 8 nibbles
    typedef union packed {
        logic [WORD_W-1:0]          bits;
        logic [NIBS-1:0][NIB_W-1:0] nibbles;
    } spi_word_u;

    ////////////////////////////////////////
    // pad modes, decoded into output enables
    ////////////////////////////////////////

    localparam logic [2:0] PAD_IDLE    = 3'd0;
    localparam logic [2:0] PAD_STD_TX  = 3'd1;
    localparam logic [2:0] PAD_STD_RX  = 3'd2;
    localparam logic [2:0] PAD_QUAD_TX = 3'd3;
    localparam logic [2:0] PAD_QUAD_RX = 3'd4;

endpackage

`default_nettype wire

/* rtl/spim_sck_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module spim_sck_gen
(
    input  logic clk_i,
    input  logic rstn_i,

    input  logic cpol_i,
    input  logic run_i,

    output logic sck_o,
    output logic lead_o,
    output logic trail_o
);

    // phase is high for the active half of each beat
    logic phase_q;

    ////////////////////////////////////////
    // phase toggle
    ////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (rstn_i == 1'b0)
        begin
            phase_q <= 1'b0;
        end
        else
        begin
            // toggle at clk/2 while a word is shifting
            if (run_i)
                phase_q <= ~phase_q;
            else
                phase_q <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // edge strobes
    ////////////////////////////////////////

    // the coming edge takes sck to its active level
    // registers acting on lead update together with that edge
    assign lead_o  = run_i & ~phase_q;

    // the coming edge returns sck to idle and tx data changes with it
    assign trail_o = phase_q;

    // idle level is cpol and the active level its inverse
    assign sck_o   = cpol_i ^ phase_q;

endmodule

`default_nettype wire

/* rtl/spim_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spim_ctrl
(
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  logic                        cmd_valid_i,
    input  logic                        cmd_rx_i,
    input  logic                        cmd_qpi_i,
    input  logic                        cmd_lsbfirst_i,
    input  logic [spim_pkg::BITS_W-1:0] cmd_bitsword_i,
    input  logic [spim_pkg::SIZE_W-1:0] cmd_size_i,
    output logic                        cmd_ready_o,

    input  logic                        tx_valid_i,
    output logic                        tx_ready_o,
    input  logic                        rx_busy_i,

    input  logic                        lead_i,
    input  logic                        trail_i,

    output logic                        run_o,
    output logic                        qpi_o,
    output logic                        lsbfirst_o,
    output logic [spim_pkg::BITS_W-1:0] bitsword_o,
    output logic [spim_pkg::BEAT_W-1:0] beat_idx_o,
    output logic [2:0]                  pad_mode_o,
    output logic                        load_o,
    output logic                        capture_start_o,
    output logic                        word_end_o,
    output logic                        done_o
);

    import spim_pkg::*;

    enum logic [1:0] {IDLE, WAIT_WORD, SHIFT, FINISH} state_q, state_d;

    logic              rx_q;
    logic              qpi_q;
    logic              lsb_q;
    logic [BITS_W-1:0] bits_q;
    logic [BEAT_W-1:0] beat_q;
    logic [BEAT_W-1:0] beat_last;
    logic [SIZE_W-1:0] words_q;
    logic              last_beat;
    logic              word_done;
    logic              cmd_take;
    logic              done_d;
    logic              done_q;

    // quad mode moves 4 bits per beat
    assign beat_last = qpi_q ? {2'b00, bits_q[BITS_W-1:2]} : bits_q;
    assign last_beat = (beat_q == beat_last);

    assign run_o     = (state_q == SHIFT);
    assign word_done = run_o & trail_i & last_beat;
    assign cmd_take  = cmd_ready_o & cmd_valid_i;

    // last sample of an rx word lands with this lead
    assign word_end_o = run_o & lead_i & last_beat & rx_q;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb
    begin
        state_d         = state_q;
        cmd_ready_o     = 1'b0;
        tx_ready_o      = 1'b0;
        load_o          = 1'b0;
        capture_start_o = 1'b0;
        done_d          = 1'b0;
        case (state_q)
            IDLE:
            begin
                cmd_ready_o = 1'b1;
                if (cmd_valid_i)
                begin
                    // rx starts right away, tx waits for its first word
                    if (cmd_rx_i)
                    begin
                        capture_start_o = 1'b1;
                        state_d         = SHIFT;
                    end
                    else
                    begin
                        state_d = WAIT_WORD;
                    end
                end
            end
            WAIT_WORD:
            begin
                if (rx_q)
                begin
                    if (!rx_busy_i)
                    begin
                        capture_start_o = 1'b1;
                        state_d         = SHIFT;
                    end
                end
                else
                begin
                    tx_ready_o = 1'b1;
                    if (tx_valid_i)
                    begin
                        load_o  = 1'b1;
                        state_d = SHIFT;
                    end
                end
            end
            SHIFT:
            begin
                if (word_done)
                begin
                    if (words_q != '0)
                    begin
                        state_d = WAIT_WORD;
                    end
                    else if (rx_busy_i)
                    begin
                        state_d = FINISH;
                    end
                    else
                    begin
                        state_d = IDLE;
                        done_d  = 1'b1;
                    end
                end
            end
            default:
            begin
                // hold until the final rx word has been taken
                if (!rx_busy_i)
                begin
                    state_d = IDLE;
                    done_d  = 1'b1;
                end
            end
        endcase
    end

    always_comb
    begin
        if (state_q == IDLE)
            pad_mode_o = PAD_IDLE;
        else if (rx_q)
            pad_mode_o = qpi_q ? PAD_QUAD_RX : PAD_STD_RX;
        else
            pad_mode_o = qpi_q ? PAD_QUAD_TX : PAD_STD_TX;
    end

    ////////////////////////////////////////
    // state, config and counters
    ////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (rstn_i == 1'b0)
        begin
            state_q <= IDLE;
            done_q  <= 1'b0;
            rx_q    <= 1'b0;
            qpi_q   <= 1'b0;
            lsb_q   <= 1'b0;
            bits_q  <= '0;
            beat_q  <= '0;
            words_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            done_q  <= done_d;
            if (cmd_take)
            begin
                rx_q    <= cmd_rx_i;
                qpi_q   <= cmd_qpi_i;
                lsb_q   <= cmd_lsbfirst_i;
                bits_q  <= cmd_bitsword_i;
                words_q <= cmd_size_i;
                beat_q  <= '0;
            end
            else if (word_done)
            begin
                beat_q <= '0;
                if (words_q != '0)
                    words_q <= words_q - 1'b1;
            end
            else if (run_o && trail_i)
            begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    assign qpi_o      = qpi_q;
    assign lsbfirst_o = lsb_q;
    assign bitsword_o = bits_q;
    assign beat_idx_o = beat_q;
    assign done_o     = done_q;

endmodule

`default_nettype wire

/* rtl/spim_tx_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module spim_tx_shift
(
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  logic [spim_pkg::WORD_W-1:0] tx_data_i,
    input  logic                        load_i,
    input  logic                        trail_i,
    input  logic                        qpi_i,
    input  logic                        lsbfirst_i,
    input  logic [spim_pkg::BITS_W-1:0] bitsword_i,
    input  logic [spim_pkg::BEAT_W-1:0] beat_idx_i,
    input  logic [2:0]                  pad_mode_i,

    output logic [spim_pkg::NIB_W-1:0]  sdo_o,
    output logic [spim_pkg::NIB_W-1:0]  oen_o
);

    import spim_pkg::*;

    spi_word_u                word_q;
    spi_word_u                src;
    logic [BEAT_W-1:0]        beat_sel;
    logic [BITS_W-1:0]        bit_idx;
    logic [$clog2(NIBS)-1:0]  nib_idx;
    logic [NIB_W-1:0]         sdo_d;
    logic [NIB_W-1:0]         sdo_q;
    logic [NIB_W-1:0]         oen_d;
    logic [NIB_W-1:0]         oen_q;
    logic                     tx_mode;
    logic                     advance;

    assign tx_mode = (pad_mode_i == PAD_STD_TX) || (pad_mode_i == PAD_QUAD_TX);
    assign advance = load_i | (trail_i & tx_mode);

    ////////////////////////////////////////
    // bit and nibble select
    ////////////////////////////////////////

    // on load the new word goes straight out at beat 0
    // on trail the next beat is presented, the counter moves with the same edge
    always_comb
    begin
        src.bits = load_i ? tx_data_i : word_q.bits;
        beat_sel = load_i ? '0 : beat_idx_i + 1'b1;
        bit_idx  = lsbfirst_i ? beat_sel : bitsword_i - beat_sel;
        nib_idx  = lsbfirst_i ? beat_sel[$clog2(NIBS)-1:0] :
                   bitsword_i[BITS_W-1:2] - beat_sel[$clog2(NIBS)-1:0];
        if (qpi_i)
            sdo_d = src.nibbles[nib_idx];
        else
            sdo_d = {{(NIB_W-1){1'b0}}, src.bits[bit_idx]};
    end

    // active low enables
    always_comb
    begin
        case (pad_mode_i)
            PAD_STD_TX, PAD_STD_RX: oen_d = 4'b1110;
            PAD_QUAD_TX:            oen_d = 4'b0000;
            default:                oen_d = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (load_i)
            word_q.bits <= tx_data_i;
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (rstn_i == 1'b0)
        begin
            sdo_q <= '0;
            oen_q <= '1;
        end
        else
        begin
            oen_q <= oen_d;
            if (advance)
                sdo_q <= sdo_d;
        end
    end

    assign sdo_o = sdo_q;
    assign oen_o = oen_q;

endmodule

`default_nettype wire

/* rtl/spim_rx_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module spim_rx_shift
(
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  logic [spim_pkg::NIB_W-1:0]  sdi_i,
    input  logic                        lead_i,
    input  logic                        capture_start_i,
    input  logic                        word_end_i,
    input  logic                        qpi_i,
    input  logic                        lsbfirst_i,
    input  logic [spim_pkg::BITS_W-1:0] bitsword_i,
    input  logic [spim_pkg::BEAT_W-1:0] beat_idx_i,

    output logic [spim_pkg::WORD_W-1:0] rx_data_o,
    output logic                        rx_valid_o,
    output logic                        rx_busy_o,
    input  logic                        rx_ready_i
);

    import spim_pkg::*;

    spi_word_u               asm_q;
    spi_word_u               asm_d;
    logic [BITS_W-1:0]       bit_idx;
    logic [$clog2(NIBS)-1:0] nib_idx;
    logic [WORD_W-1:0]       data_q;
    logic                    valid_q;

    ////////////////////////////////////////
    // word assembly
    ////////////////////////////////////////

    // sdi1 in standard mode, sdi3..sdi0 as one nibble in quad mode
    always_comb
    begin
        bit_idx = lsbfirst_i ? beat_idx_i : bitsword_i - beat_idx_i;
        nib_idx = lsbfirst_i ? beat_idx_i[$clog2(NIBS)-1:0] :
                  bitsword_i[BITS_W-1:2] - beat_idx_i[$clog2(NIBS)-1:0];
        asm_d = asm_q;
        if (qpi_i)
            asm_d.nibbles[nib_idx] = sdi_i;
        else
            asm_d.bits[bit_idx] = sdi_i[1];
    end

    // cleared per word so that bits above the word length read as zero
    always_ff @(posedge clk_i)
    begin
        if (capture_start_i)
            asm_q.bits <= '0;
        else if (lead_i)
            asm_q <= asm_d;
    end

    // word_end comes with the last lead, so take the merged value
    always_ff @(posedge clk_i)
    begin
        if (word_end_i)
            data_q <= asm_d.bits;
    end

    ////////////////////////////////////////
    // receive handshake
    ////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (rstn_i == 1'b0)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            if (word_end_i)
                valid_q <= 1'b1;
            else if (rx_ready_i)
                valid_q <= 1'b0;
        end
    end

    // a word accepted this cycle no longer blocks the next one
    assign rx_busy_o  = valid_q & ~rx_ready_i;
    assign rx_valid_o = valid_q;
    assign rx_data_o  = data_q;

endmodule

`default_nettype wire

/* rtl/spim_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spim_top
(
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  logic                        cmd_valid_i,
    output logic                        cmd_ready_o,
    input  logic                        cmd_rx_i,
    input  logic                        cmd_qpi_i,
    input  logic                        cmd_lsbfirst_i,
    input  logic [spim_pkg::BITS_W-1:0] cmd_bitsword_i,
    input  logic [spim_pkg::SIZE_W-1:0] cmd_size_i,

    input  logic                        cpol_i,

    input  logic [spim_pkg::WORD_W-1:0] tx_data_i,
    input  logic                        tx_valid_i,
    output logic                        tx_ready_o,

    output logic [spim_pkg::WORD_W-1:0] rx_data_o,
    output logic                        rx_valid_o,
    input  logic                        rx_ready_i,

    output logic                        done_o,

    output logic                        sck_o,
    output logic [spim_pkg::NIB_W-1:0]  sdo_o,
    output logic [spim_pkg::NIB_W-1:0]  oen_o,
    input  logic [spim_pkg::NIB_W-1:0]  sdi_i
);

    import spim_pkg::*;

    logic              run;
    logic              lead;
    logic              trail;
    logic              qpi;
    logic              lsbfirst;
    logic [BITS_W-1:0] bitsword;
    logic [BEAT_W-1:0] beat_idx;
    logic [2:0]        pad_mode;
    logic              load;
    logic              capture_start;
    logic              word_end;
    logic              rx_busy;

    ////////////////////////////////////////
    // clock and control
    ////////////////////////////////////////

    spim_sck_gen i_sck_gen
    (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .cpol_i  (cpol_i),
        .run_i   (run),
        .sck_o   (sck_o),
        .lead_o  (lead),
        .trail_o (trail)
    );

    spim_ctrl i_ctrl
    (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .cmd_valid_i     (cmd_valid_i),
        .cmd_rx_i        (cmd_rx_i),
        .cmd_qpi_i       (cmd_qpi_i),
        .cmd_lsbfirst_i  (cmd_lsbfirst_i),
        .cmd_bitsword_i  (cmd_bitsword_i),
        .cmd_size_i      (cmd_size_i),
        .cmd_ready_o     (cmd_ready_o),
        .tx_valid_i      (tx_valid_i),
        .tx_ready_o      (tx_ready_o),
        .rx_busy_i       (rx_busy),
        .lead_i          (lead),
        .trail_i         (trail),
        .run_o           (run),
        .qpi_o           (qpi),
        .lsbfirst_o      (lsbfirst),
        .bitsword_o      (bitsword),
        .beat_idx_o      (beat_idx),
        .pad_mode_o      (pad_mode),
        .load_o          (load),
        .capture_start_o (capture_start),
        .word_end_o      (word_end),
        .done_o          (done_o)
    );

    ////////////////////////////////////////
    // data paths
    ////////////////////////////////////////

    spim_tx_shift i_tx_shift
    (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .tx_data_i  (tx_data_i),
        .load_i     (load),
        .trail_i    (trail),
        .qpi_i      (qpi),
        .lsbfirst_i (lsbfirst),
        .bitsword_i (bitsword),
        .beat_idx_i (beat_idx),
        .pad_mode_i (pad_mode),
        .sdo_o      (sdo_o),
        .oen_o      (oen_o)
    );

    spim_rx_shift i_rx_shift
    (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .sdi_i           (sdi_i),
        .lead_i          (lead),
        .capture_start_i (capture_start),
        .word_end_i      (word_end),
        .qpi_i           (qpi),
        .lsbfirst_i      (lsbfirst),
        .bitsword_i      (bitsword),
        .beat_idx_i      (beat_idx),
        .rx_data_o       (rx_data_o),
        .rx_valid_o      (rx_valid_o),
        .rx_busy_o       (rx_busy),
        .rx_ready_i      (rx_ready_i)
    );

endmodule

`default_nettype wire

/* test/tb_spim_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spim_sva
(
    input logic                        clk_i,
    input logic                        rstn_i,
    input logic                        cmd_valid_i,
    input logic                        cmd_ready_o,
    input logic                        cmd_rx_i,
    input logic                        cmd_qpi_i,
    input logic                        cmd_lsbfirst_i,
    input logic [spim_pkg::BITS_W-1:0] cmd_bitsword_i,
    input logic [spim_pkg::SIZE_W-1:0] cmd_size_i,
    input logic                        cpol_i,
    input logic [spim_pkg::WORD_W-1:0] tx_data_i,
    input logic                        tx_valid_i,
    input logic                        tx_ready_o,
    input logic [spim_pkg::WORD_W-1:0] rx_data_o,
    input logic                        rx_valid_o,
    input logic                        rx_ready_i,
    input logic                        done_o,
    input logic                        sck_o
);

    // number of assertion failures so far
    int fail_count = 0;

    ////////////////////////////////////////
    // handshake stability
    ////////////////////////////////////////

    cmd_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd_valid_i && !cmd_ready_o |=> cmd_valid_i &&
        $stable({cmd_rx_i, cmd_qpi_i, cmd_lsbfirst_i, cmd_bitsword_i, cmd_size_i}))
    else
    begin
        $error("command valid dropped or fields changed before acceptance");
        fail_count++;
    end

    tx_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        tx_valid_i && !tx_ready_o |=> tx_valid_i && $stable(tx_data_i))
    else
    begin
        $error("tx valid dropped or tx data changed before acceptance");
        fail_count++;
    end

    // the DUT side of the receive port
    rx_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o))
    else
    begin
        $error("rx valid dropped or rx data changed before acceptance");
        fail_count++;
    end

    ////////////////////////////////////////
    // clock and completion
    ////////////////////////////////////////

    sck_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd_ready_o && $past(cmd_ready_o) && $stable(cpol_i) |-> $stable(sck_o))
    else
    begin
        $error("sck toggled while the engine is idle");
        fail_count++;
    end

    done_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_o |=> !done_o)
    else
    begin
        $error("done held high for more than one cycle");
        fail_count++;
    end

endmodule

`default_nettype wire

/* test/tb_spim.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spim;

    import spim_pkg::*;

    localparam int NUM_CMDS     = 40;
    localparam int MAX_WORDS    = 6;
    localparam int MAX_GAP      = 8;
    // every word at full length, with room for gaps and rx back-pressure
    localparam int LIMIT_CYCLES = 4 * NUM_CMDS * MAX_WORDS * (2 * WORD_W + 4 * MAX_GAP) + 200;

    logic              clk_i = 1'b0;
    logic              rstn_i;
    logic              cmd_valid_i;
    logic              cmd_ready_o;
    logic              cmd_rx_i;
    logic              cmd_qpi_i;
    logic              cmd_lsbfirst_i;
    logic [BITS_W-1:0] cmd_bitsword_i;
    logic [SIZE_W-1:0] cmd_size_i;
    logic              cpol_i;
    logic [WORD_W-1:0] tx_data_i;
    logic              tx_valid_i;
    logic              tx_ready_o;
    logic [WORD_W-1:0] rx_data_o;
    logic              rx_valid_o;
    logic              rx_ready_i;
    logic              done_o;
    logic              sck_o;
    logic [NIB_W-1:0]  sdo_o;
    logic [NIB_W-1:0]  oen_o;
    logic [NIB_W-1:0]  sdi_i;

    logic [31:0]       rng_state = 32'h56d6_fe2c;
    int                err_count = 0;
    int                check_count = 0;

    // current command as seen by the model
    logic              cur_rx;
    logic              cur_qpi;
    logic              cur_lsb;
    int                cur_bits;
    int                cur_nwords;
    int                cur_bpw;
    logic [WORD_W-1:0] tx_words [MAX_WORDS];
    logic [WORD_W-1:0] slave_words [MAX_WORDS];

    // slave monitor state
    spi_word_u         seen_word;
    int                mon_beat = 0;
    int                mon_word = 0;
    int                lead_cnt = 0;
    int                done_cnt = 0;

    always #5 clk_i = ~clk_i;

    spim_top i_spim_top
    (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_ready_o    (cmd_ready_o),
        .cmd_rx_i       (cmd_rx_i),
        .cmd_qpi_i      (cmd_qpi_i),
        .cmd_lsbfirst_i (cmd_lsbfirst_i),
        .cmd_bitsword_i (cmd_bitsword_i),
        .cmd_size_i     (cmd_size_i),
        .cpol_i         (cpol_i),
        .tx_data_i      (tx_data_i),
        .tx_valid_i     (tx_valid_i),
        .tx_ready_o     (tx_ready_o),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .rx_ready_i     (rx_ready_i),
        .done_o         (done_o),
        .sck_o          (sck_o),
        .sdo_o          (sdo_o),
        .oen_o          (oen_o),
        .sdi_i          (sdi_i)
    );

    bind spim_top tb_spim_sva i_spim_sva
    (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_ready_o    (cmd_ready_o),
        .cmd_rx_i       (cmd_rx_i),
        .cmd_qpi_i      (cmd_qpi_i),
        .cmd_lsbfirst_i (cmd_lsbfirst_i),
        .cmd_bitsword_i (cmd_bitsword_i),
        .cmd_size_i     (cmd_size_i),
        .cpol_i         (cpol_i),
        .tx_data_i      (tx_data_i),
        .tx_valid_i     (tx_valid_i),
        .tx_ready_o     (tx_ready_o),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .rx_ready_i     (rx_ready_i),
        .done_o         (done_o),
        .sck_o          (sck_o)
    );

    ////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // low bitsword+1 bits of a word
    function automatic logic [WORD_W-1:0] word_mask();
        logic [63:0] m;
        m = (64'd1 << (cur_bits + 1)) - 64'd1;
        return m[WORD_W-1:0];
    endfunction

    // bit (standard) or nibble (quad) index carried by beat k
    function automatic int beat_pos(input int k);
        int top;
        top = cur_qpi ? cur_bits / 4 : cur_bits;
        return cur_lsb ? k : top - k;
    endfunction

    function automatic logic [NIB_W-1:0] slave_beat(input int w, input int k);
        spi_word_u        sw;
        logic [NIB_W-1:0] lines;
        sw.bits = slave_words[w];
        if (cur_qpi)
            lines = sw.nibbles[beat_pos(k)];
        else
            // data on sdi1, its inverse on sdi0 to expose a wrong lane
            lines = {2'b00, sw.bits[beat_pos(k)], ~sw.bits[beat_pos(k)]};
        return lines;
    endfunction

    function automatic logic [NIB_W-1:0] oen_expected();
        logic [NIB_W-1:0] oen;
        if (!cur_qpi)
            oen = 4'b1110;
        else if (cur_rx)
            oen = 4'b1111;
        else
            oen = 4'b0000;
        return oen;
    endfunction

    task automatic check_equal(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                               input string what);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // SPI slave model
    ////////////////////////////////////////

    // one sck active cycle per beat, the edge that ends it is the trailing edge
    always @(posedge clk_i)
    begin
        if (rstn_i)
        begin
            if (done_o)
                done_cnt++;
            if (cmd_ready_o)
            begin
                check_equal(WORD_W'(sck_o), WORD_W'(cpol_i), "sck level while idle");
            end
            else if (sck_o !== cpol_i)
            begin
                lead_cnt++;
                check_equal(WORD_W'(oen_o), WORD_W'(oen_expected()), "oen during shift");
                if (!cur_rx)
                begin
                    if (cur_qpi)
                        seen_word.nibbles[beat_pos(mon_beat)] = sdo_o;
                    else
                        seen_word.bits[beat_pos(mon_beat)] = sdo_o[0];
                end
                mon_beat++;
                if (mon_beat == cur_bpw)
                begin
                    if (!cur_rx && mon_word < cur_nwords)
                        check_equal(seen_word.bits, tx_words[mon_word] & word_mask(),
                                    "tx word on sdo");
                    seen_word.bits = '0;
                    mon_beat = 0;
                    mon_word++;
                end
                if (cur_rx && mon_word < cur_nwords)
                    sdi_i <= slave_beat(mon_word, mon_beat);
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic issue_command();
        logic [31:0] r;
        logic        cpol_new;
        r = xorshift32();
        cur_rx   = r[0];
        cur_qpi  = r[1];
        cur_lsb  = r[2];
        cpol_new = r[3];
        cur_nwords = 1 + int'(xorshift32() % MAX_WORDS);
        r = xorshift32();
        // quad words are whole nibbles
        cur_bits = cur_qpi ? 4 * int'(r % 8) + 3 : int'(r % 32);
        cur_bpw  = cur_qpi ? (cur_bits + 1) / 4 : cur_bits + 1;
        for (int i = 0; i < MAX_WORDS; i++)
        begin
            tx_words[i]    = xorshift32();
            slave_words[i] = xorshift32();
        end
        mon_beat       = 0;
        mon_word       = 0;
        lead_cnt       = 0;
        seen_word.bits = '0;
        @(posedge clk_i);
        cpol_i <= cpol_new;
        @(posedge clk_i);
        cmd_valid_i    <= 1'b1;
        cmd_rx_i       <= cur_rx;
        cmd_qpi_i      <= cur_qpi;
        cmd_lsbfirst_i <= cur_lsb;
        cmd_bitsword_i <= BITS_W'(cur_bits);
        cmd_size_i     <= SIZE_W'(cur_nwords - 1);
        // first receive beat must be on sdi before the first leading edge
        if (cur_rx)
            sdi_i <= slave_beat(0, 0);
        do
            @(posedge clk_i);
        while (!cmd_ready_o);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic feed_tx();
        int gap;
        for (int w = 0; w < cur_nwords; w++)
        begin
            gap = int'(xorshift32() % MAX_GAP);
            repeat (gap) @(posedge clk_i);
            @(posedge clk_i);
            tx_valid_i <= 1'b1;
            tx_data_i  <= tx_words[w];
            do
                @(posedge clk_i);
            while (!tx_ready_o);
            tx_valid_i <= 1'b0;
        end
    endtask

    task automatic drain_rx();
        int          got;
        logic [31:0] r;
        got = 0;
        while (got < cur_nwords)
        begin
            @(posedge clk_i);
            if (rx_valid_o && rx_ready_i)
            begin
                check_equal(rx_data_o, slave_words[got] & word_mask(), "rx word");
                got++;
            end
            r = xorshift32();
            rx_ready_i <= r[0];
        end
        rx_ready_i <= 1'b0;
    endtask

    task automatic wait_done();
        do
        begin
            @(posedge clk_i);
            if (!done_o)
                check_equal(WORD_W'(cmd_ready_o), 32'd0, "cmd_ready during command");
        end
        while (!done_o);
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial
    begin
        rstn_i         = 1'b0;
        cmd_valid_i    = 1'b0;
        cmd_rx_i       = 1'b0;
        cmd_qpi_i      = 1'b0;
        cmd_lsbfirst_i = 1'b0;
        cmd_bitsword_i = '0;
        cmd_size_i     = '0;
        cpol_i         = 1'b0;
        tx_data_i      = '0;
        tx_valid_i     = 1'b0;
        rx_ready_i     = 1'b0;
        sdi_i          = '0;
        cur_rx         = 1'b0;
        cur_qpi        = 1'b0;
        cur_lsb        = 1'b0;
        cur_bits       = 0;
        cur_nwords     = 0;
        cur_bpw        = 1;
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        for (int c = 0; c < NUM_CMDS; c++)
        begin
            issue_command();
            fork
                if (!cur_rx)
                    feed_tx();
                if (cur_rx)
                    drain_rx();
                wait_done();
            join
            @(posedge clk_i);
            check_equal(lead_cnt, cur_nwords * cur_bpw, "leading edges per command");
            check_equal(done_cnt, c + 1, "done pulses so far");
        end
        repeat (8) @(posedge clk_i);
        check_equal(done_cnt, NUM_CMDS, "done pulses in total");
        err_count += i_spim_top.i_spim_sva.fail_count;
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        #(LIMIT_CYCLES * 10);
        $display("timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/spim_pkg.sv
rtl/spim_sck_gen.sv
rtl/spim_ctrl.sv
rtl/spim_tx_shift.sv
rtl/spim_rx_shift.sv
rtl/spim_top.sv
test/tb_spim_sva.sv
test/tb_spim.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_spim \
    -f tb.f -o tb_spim \
    && ./obj_dir/tb_spim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
